//--- list.f
+incdir+verilog
verilog/udma_tx_cfg_pkg.sv
verilog/udma_tx_bus_pkg.sv
verilog/tx_arbiter.sv
verilog/tx_req_fifo.sv
verilog/tx_l2_reader.sv
verilog/tx_rdata_align.sv
verilog/udma_tx_top.sv
testbench/udma_tx_checker.sv
testbench/tb_udma_tx.sv

//--- run.sh
#!/bin/sh
# build with Verilator from the project root, then look for the pass line in the log
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert --top-module tb_udma_tx -f list.f -o tb_udma_tx \
    && ./obj_dir/tb_udma_tx > sim.log 2>&1
cat sim.log 2>/dev/null
grep -qx "=== PASS ===" sim.log && echo "run passed" && exit 0 || echo "run failed" && exit 1

//--- testbench/tb_udma_tx.sv
// testbench of the uDMA transmit read path, run from the project root
// transfers and expected data come from testbench/tx_stimulus.txt
// the L2 model grants on LFSR bits and answers each grant one cycle later
`timescale 1ns/1ps
`include "udma_tx_settings.svh"

module tb_udma_tx;
    import udma_tx_cfg_pkg::*;
    import udma_tx_bus_pkg::*;

    localparam int N_LINES  = 12;
    localparam int HOLD_CYC = 24;
    localparam int MAX_CYC  = 60 * N_LINES + 100;

    logic                      clk_i        = 1'b0;
    logic                      rstn_i       = 1'b0;
    logic    [`TX_N_CH-1:0]    ch_req_valid = '0;
    ch_req_t [`TX_N_CH-1:0]    ch_req       = '0;
    logic    [`TX_N_CH-1:0]    ch_gnt;
    ch_rsp_t [`TX_N_CH-1:0]    ch_rsp;
    logic                      l2_req;
    logic                      l2_gnt       = 1'b0;
    logic    [31:0]            l2_addr;
    logic                      l2_rvalid    = 1'b0;
    logic    [31:0]            l2_rdata     = '0;

    logic [31:0] stim [4*N_LINES];
    int          ch_lines [`TX_N_CH][$];
    int          gnt_cnt [`TX_N_CH];
    int          rsp_cnt [`TX_N_CH];
    int          pend [$];
    int          data_errs    = 0;
    int          addr_errs    = 0;
    int          flow_errs    = 0;
    int          rsp_total    = 0;
    int          l2_grants    = 0;
    int          ch_grants    = 0;
    int          early_grants = 0;
    int          exp_beats    = 0;
    int          cycle        = 0;
    int          beat         = 0;
    logic [7:0]  lfsr_q       = 8'd62;
    logic        rd_seen      = 1'b0;
    logic [31:0] rd_addr      = '0;

    udma_tx_top udma_tx_top_i
    (
        .clk_i(clk_i), .rstn_i(rstn_i), .ch_req_valid_i(ch_req_valid), .ch_req_i(ch_req),
        .ch_gnt_o(ch_gnt), .ch_rsp_o(ch_rsp), .l2_req_o(l2_req), .l2_gnt_i(l2_gnt),
        .l2_addr_o(l2_addr), .l2_rvalid_i(l2_rvalid), .l2_rdata_i(l2_rdata)
    );

    bind udma_tx_top udma_tx_checker u_checker
    (
        .clk_i(clk_i), .rstn_i(rstn_i), .gnt_i(ch_gnt_o), .rsp_i(ch_rsp_o),
        .l2_req_i(l2_req_o), .l2_gnt_i(l2_gnt_i), .l2_addr_i(l2_addr_o)
    );

    always #20 clk_i = ~clk_i;

    //////////////////////////////////////////////////////////////////////
    // reference rules
    //////////////////////////////////////////////////////////////////////

    // 8-bit Fibonacci LFSR, taps 8 6 5 4
    function automatic logic [7:0] lfsr_step(input logic [7:0] s);
        return {s[6:0], s[7] ^ s[5] ^ s[4] ^ s[3]};
    endfunction

    // n memory bytes from addr upward, lowest address in the low bits
    function automatic logic [31:0] byte_seq(input logic [31:0] addr, input int n);
        logic [31:0] d;
        d = '0;
        for (int i = 0; i < n; i++)
            d[8*i +: 8] = 8'((addr + i) * 7 + 3);
        return d;
    endfunction

    // halfword at lane 3 or word off lane 0 crosses into the next word
    function automatic bit is_split(input int line);
        logic [1:0] lane;
        logic [1:0] size;
        lane = stim[4*line+1][1:0];
        size = stim[4*line+2][1:0];
        return (size == 2'd1 && lane == 2'd3) || (size == 2'd2 && lane != 2'd0);
    endfunction

    task automatic drive_channel(input ch_idx_t c);
        int idx;
        for (int k = 0; k < ch_lines[c].size(); k++)
        begin
            idx = ch_lines[c][k];
            @(posedge clk_i);
            ch_req_valid[c] <= 1'b1;
            ch_req[c]       <= '{addr: l2_addr_t'(stim[4*idx+1]),
                                 size: tx_size_e'(stim[4*idx+2][1:0])};
            do
                @(negedge clk_i);
            while (!ch_gnt[c]);
        end
        @(posedge clk_i);
        ch_req_valid[c] <= 1'b0;
    endtask

    task automatic finish_run();
        $display("summary data errors %0d address errors %0d flow errors %0d",
                 data_errs, addr_errs, flow_errs);
        if (data_errs + addr_errs + flow_errs == 0)
            $display("=== PASS ===");
        else
            $display("=== FAIL ===");
        $finish;
    endtask

    //////////////////////////////////////////////////////////////////////
    // L2 memory model and run limit
    //////////////////////////////////////////////////////////////////////
    always @(posedge clk_i)
    begin
        cycle++;
        if (cycle >= MAX_CYC)
        begin
            $display("timeout after %0d cycles with %0d of %0d responses",
                     cycle, rsp_total, N_LINES);
            flow_errs++;
            finish_run();
        end
        else
        begin
            l2_rvalid <= rd_seen;
            l2_rdata  <= byte_seq(rd_addr, 4);
            // no memory grant during the first cycles so the buffer fills up
            if (rstn_i && cycle > HOLD_CYC)
            begin
                lfsr_q = lfsr_step(lfsr_q);
                l2_gnt <= lfsr_q[0];
            end
            else
                l2_gnt <= 1'b0;
        end
    end

    // sampled at the falling edge, where all DUT outputs are settled
    always @(negedge clk_i)
    begin
        logic [31:0] exp_addr;
        int          idx;
        if (rstn_i)
        begin
            rd_seen = l2_req && l2_gnt;
            rd_addr = l2_addr;
            if (l2_req && (l2_addr[31:20] != 12'h1C0 || l2_addr[1:0] != 2'b00))
            begin
                $display("error l2 address format expected 1c0 prefix and word aligned actual %h",
                         l2_addr);
                addr_errs++;
            end
            if (rd_seen)
            begin
                l2_grants++;
                if (pend.size() == 0)
                begin
                    $display("memory granted a read with no channel request in flight");
                    flow_errs++;
                end
                else
                begin
                    exp_addr = {12'h1C0, stim[4*pend[0]+1][19:2] + 18'(beat), 2'b00};
                    if (l2_addr !== exp_addr)
                    begin
                        $display("error line %0d beat %0d address expected %h actual %h",
                                 pend[0], beat, exp_addr, l2_addr);
                        addr_errs++;
                    end
                    if (beat == 1 || !is_split(pend[0]))
                    begin
                        void'(pend.pop_front());
                        beat = 0;
                    end
                    else
                        beat = 1;
                end
            end
            for (int c = 0; c < `TX_N_CH; c++)
            begin
                if (ch_gnt[ch_idx_t'(c)])
                begin
                    pend.push_back(ch_lines[ch_idx_t'(c)][gnt_cnt[ch_idx_t'(c)]]);
                    gnt_cnt[ch_idx_t'(c)]++;
                    ch_grants++;
                    if (l2_grants == 0)
                        early_grants++;
                    if (ch_grants <= `TX_N_CH && gnt_cnt[ch_idx_t'(c)] > 1)
                    begin
                        $display("channel %0d granted twice before all channels had a grant", c);
                        flow_errs++;
                    end
                end
                if (ch_rsp[ch_idx_t'(c)].valid)
                begin
                    rsp_total++;
                    if (rsp_cnt[ch_idx_t'(c)] >= ch_lines[ch_idx_t'(c)].size())
                    begin
                        $display("response on channel %0d which has no request left", c);
                        flow_errs++;
                    end
                    else
                    begin
                        idx = ch_lines[ch_idx_t'(c)][rsp_cnt[ch_idx_t'(c)]];
                        if (ch_rsp[ch_idx_t'(c)].data !== stim[4*idx+3])
                        begin
                            $display("error line %0d data expected %h actual %h",
                                     idx, stim[4*idx+3], ch_rsp[ch_idx_t'(c)].data);
                            data_errs++;
                        end
                        rsp_cnt[ch_idx_t'(c)]++;
                    end
                end
            end
        end
    end

    //////////////////////////////////////////////////////////////////////
    // main sequence
    //////////////////////////////////////////////////////////////////////
    initial
    begin
        $readmemh("testbench/tx_stimulus.txt", stim);
        for (int i = 0; i < N_LINES; i++)
        begin
            ch_lines[stim[4*i][1:0]].push_back(i);
            exp_beats += is_split(i) ? 2 : 1;
            // the file must agree with the memory fill rule
            if (byte_seq(stim[4*i+1], 1 << stim[4*i+2]) !== stim[4*i+3])
            begin
                $display("error line %0d stimulus expected %h actual %h",
                         i, byte_seq(stim[4*i+1], 1 << stim[4*i+2]), stim[4*i+3]);
                data_errs++;
            end
        end
        repeat (4) @(posedge clk_i);
        rstn_i <= 1'b1;

        // all four channels start requesting in the same cycle
        fork
            drive_channel(2'd0);
            drive_channel(2'd1);
            drive_channel(2'd2);
            drive_channel(2'd3);
        join

        wait (rsp_total >= N_LINES);
        repeat (10) @(posedge clk_i);
        if (rsp_total != N_LINES)
        begin
            $display("error response count expected %0d actual %0d", N_LINES, rsp_total);
            flow_errs++;
        end
        if (l2_grants != exp_beats)
        begin
            $display("error l2 grant count expected %0d actual %0d", exp_beats, l2_grants);
            flow_errs++;
        end
        if (early_grants > 5)
        begin
            $display("error grants before first memory grant expected at most 5 actual %0d",
                     early_grants);
            flow_errs++;
        end
        if (pend.size() != 0)
        begin
            $display("%0d granted requests were never read from memory", pend.size());
            flow_errs++;
        end
        finish_run();
    end

endmodule

//--- testbench/tx_stimulus.txt
// channel  byte address  size 0 byte 1 half 2 word  expected data
// one transfer per line, all values in hex
0 00010 0 00000073
1 00044 1 0000e6df
2 00080 2 98918a83
3 00033 0 00000068
0 00123 1 0000fff8
1 00201 2 1f18110a
2 00347 2 0902fbf4
3 00402 1 00001811
0 01002 2 261f1811
1 0abc6 1 0000746d
2 ffffd 0 000000ee
3 7ffff 2 110a03fc

//--- testbench/udma_tx_checker.sv
// protocol assertions bound into udma_tx_top
// rsp_i carries one response entry per channel
`timescale 1ns/1ps
`include "udma_tx_settings.svh"

module udma_tx_checker
(
    input logic                                     clk_i,
    input logic                                     rstn_i,
    input logic [`TX_N_CH-1:0]                      gnt_i,
    input udma_tx_bus_pkg::ch_rsp_t [`TX_N_CH-1:0]  rsp_i,
    input logic                                     l2_req_i,
    input logic                                     l2_gnt_i,
    input logic [`TX_L2_DW-1:0]                     l2_addr_i
);
    logic [`TX_N_CH-1:0] rsp_valid;

    always_comb
    begin
        for (int i = 0; i < `TX_N_CH; i++)
            rsp_valid[i] = rsp_i[i].valid;
    end

    gnt_onehot: assert property (@(posedge clk_i) disable iff (!rstn_i) $onehot0(gnt_i))
        else $error("more than one channel granted in a cycle");

    // a pending read keeps its address until the memory grants it
    addr_hold: assert property (@(posedge clk_i) disable iff (!rstn_i)
        l2_req_i && !l2_gnt_i |=> $stable(l2_addr_i))
        else $error("l2 address changed while the read was waiting for a grant");

    rsp_onehot: assert property (@(posedge clk_i) disable iff (!rstn_i) $onehot0(rsp_valid))
        else $error("more than one channel response valid in a cycle");

endmodule

//--- verilog/tx_arbiter.sv
// round-robin arbiter in front of the request buffer
// a channel keeps valid and request stable until its grant bit is seen
// grants are withheld while the buffer reports no room
`timescale 1ns/1ps
`include "udma_tx_settings.svh"

module tx_arbiter
(
    input  logic                                      clk_i,
    input  logic                                      rstn_i,
    input  logic              [`TX_N_CH-1:0]          req_valid_i,
    input  udma_tx_bus_pkg::ch_req_t [`TX_N_CH-1:0]   req_i,
    input  logic                                      room_i,
    output logic              [`TX_N_CH-1:0]          gnt_o,
    output logic                                      push_o,
    output udma_tx_bus_pkg::tx_entry_t                entry_o
);
    import udma_tx_cfg_pkg::*;
    import udma_tx_bus_pkg::*;

    ch_idx_t   rr_q;
    ch_idx_t   win;
    ch_idx_t   cand;
    logic      found;
    logic      grant_any;
    logic      push_q;
    tx_entry_t entry_q;

    // first requester at or after the pointer
    always_comb
    begin
        found = 1'b0;
        win   = rr_q;
        cand  = rr_q;
        for (int k = 0; k < `TX_N_CH; k++)
        begin
            cand = rr_q + ch_idx_t'(k);
            if (!found && req_valid_i[cand])
            begin
                found = 1'b1;
                win   = cand;
            end
        end
    end

    assign grant_any = found & room_i;

    always_comb
    begin
        gnt_o = '0;
        if (grant_any)
            gnt_o[win] = 1'b1;
    end

    always_ff @(posedge clk_i or negedge rstn_i)
    begin
        if (!rstn_i)
        begin
            rr_q   <= '0;
            push_q <= 1'b0;
        end
        else
        begin
            push_q <= grant_any;
            if (grant_any)
                rr_q <= win + ch_idx_t'(1);
        end
    end

    // winning request with its channel, pushed one cycle after the grant
    always_ff @(posedge clk_i)
    begin
        if (grant_any)
            entry_q <= '{ch: win, size: req_i[win].size, addr: req_i[win].addr};
    end

    assign push_o  = push_q;
    assign entry_o = entry_q;

endmodule

//--- verilog/tx_l2_reader.sv
// issues L2 word reads for the head entry of the request buffer
// non-aligned halfwords and words take two reads, the entry pops after the last
// the memory must answer each grant with rvalid exactly one cycle later
`timescale 1ns/1ps
`include "udma_tx_settings.svh"

module tx_l2_reader
(
    input  logic                       clk_i,
    input  logic                       rstn_i,
    input  udma_tx_bus_pkg::tx_entry_t head_i,
    input  logic                       not_empty_i,
    output logic                       pop_o,
    output logic                       l2_req_o,
    input  logic                       l2_gnt_i,
    output logic [`TX_L2_DW-1:0]       l2_addr_o,
    output udma_tx_bus_pkg::rd_tag_t   tag_o
);
    import udma_tx_cfg_pkg::*;
    import udma_tx_bus_pkg::*;

    typedef enum logic {RD_IDLE, RD_SECOND} rd_state_e;

    rd_state_e            state_q;
    lane_t                lane;
    logic                 is_na;
    logic                 granted;
    logic                 last_beat;
    logic [`TX_L2_AW-3:0] word_addr;
    rd_tag_t              tag_q;

    assign lane = head_i.addr[1:0];

    // split when the access crosses the word boundary
    always_comb
    begin
        case (head_i.size)
            HALF:    is_na = (lane == 2'd3);
            WORD:    is_na = (lane != 2'd0);
            default: is_na = 1'b0;
        endcase
    end

    assign l2_req_o  = not_empty_i;
    assign granted   = l2_req_o & l2_gnt_i;
    assign last_beat = (state_q == RD_SECOND) | ~is_na;
    assign pop_o     = granted & last_beat;

    // second beat reads the following word
    assign word_addr = head_i.addr[`TX_L2_AW-1:2] + {{(`TX_L2_AW-3){1'b0}}, state_q == RD_SECOND};
    assign l2_addr_o = {`TX_L2_PREFIX, word_addr, 2'b00};

    always_ff @(posedge clk_i or negedge rstn_i)
    begin
        if (!rstn_i)
            state_q <= RD_IDLE;
        else if (granted)
            state_q <= (state_q == RD_IDLE && is_na) ? RD_SECOND : RD_IDLE;
    end

    always_ff @(posedge clk_i)
    begin
        if (granted)
            tag_q <= '{ch: head_i.ch, size: head_i.size, lane: lane,
                       first: (state_q == RD_IDLE), last: last_beat};
    end

    assign tag_o = tag_q;

endmodule

//--- verilog/tx_rdata_align.sv
// extracts the addressed bytes from returned L2 words and routes them back
// tag_i is only meaningful in the cycle where l2_rvalid_i is high
// the response strobe comes one cycle after the final rvalid
`timescale 1ns/1ps
`include "udma_tx_settings.svh"

module tx_rdata_align
(
    input  logic                                     clk_i,
    input  logic                                     rstn_i,
    input  udma_tx_bus_pkg::rd_tag_t                 tag_i,
    input  logic                                     l2_rvalid_i,
    input  logic [`TX_L2_DW-1:0]                     l2_rdata_i,
    output udma_tx_bus_pkg::ch_rsp_t [`TX_N_CH-1:0]  rsp_o
);
    import udma_tx_cfg_pkg::*;

    logic [`TX_L2_DW-1:0] low_part;
    logic [`TX_L2_DW-1:0] high_part;
    logic [`TX_L2_DW-1:0] merged;
    logic [`TX_L2_DW-1:0] masked;
    logic [`TX_L2_DW-1:0] partial_q;
    logic [`TX_L2_DW-1:0] data_q;
    logic [2:0]           head_bytes;
    logic [`TX_N_CH-1:0]  valid_q;

    // bytes of the first word that belong to the transfer
    assign head_bytes = 3'd4 - {1'b0, tag_i.lane};
    assign low_part   = l2_rdata_i >> {tag_i.lane, 3'b000};
    assign high_part  = l2_rdata_i << {head_bytes, 3'b000};
    assign merged     = tag_i.first ? low_part : (partial_q | high_part);

    always_comb
    begin
        case (tag_i.size)
            BYTE:    masked = {24'h0, merged[7:0]};
            HALF:    masked = {16'h0, merged[15:0]};
            default: masked = merged;
        endcase
    end

    always_ff @(posedge clk_i or negedge rstn_i)
    begin
        if (!rstn_i)
            valid_q <= '0;
        else
            for (int i = 0; i < `TX_N_CH; i++)
                valid_q[i] <= l2_rvalid_i & tag_i.last & (tag_i.ch == ch_idx_t'(i));
    end

    always_ff @(posedge clk_i)
    begin
        if (l2_rvalid_i && tag_i.first)
            partial_q <= low_part;
        if (l2_rvalid_i && tag_i.last)
            data_q <= masked;
    end

    // data is shared, only the tagged channel sees valid
    always_comb
    begin
        for (int i = 0; i < `TX_N_CH; i++)
            rsp_o[i] = '{valid: valid_q[i], data: data_q};
    end

endmodule

//--- verilog/tx_req_fifo.sv
// circular buffer of pending read requests, payload given by ENTRY_T
// room_o counts the push still in flight one cycle after a grant
// a pop in the same cycle is not credited, room is conservative
`timescale 1ns/1ps
`include "udma_tx_settings.svh"

module tx_req_fifo
#(
    parameter type ENTRY_T = logic,
    parameter int  DEPTH   = `TX_FIFO_DEPTH
)
(
    input  logic   clk_i,
    input  logic   rstn_i,
    input  logic   push_i,
    input  ENTRY_T data_i,
    input  logic   pop_i,
    output ENTRY_T data_o,
    output logic   not_empty_o,
    output logic   room_o
);
    localparam int PW = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CW = $clog2(DEPTH + 1);

    ENTRY_T        mem_q [DEPTH];
    logic [PW-1:0] wr_ptr_q;
    logic [PW-1:0] rd_ptr_q;
    logic [CW-1:0] count_q;

    function automatic logic [PW-1:0] ptr_next(input logic [PW-1:0] ptr);
        return (int'(ptr) == DEPTH - 1) ? '0 : ptr + 1'b1;
    endfunction

    assign data_o      = mem_q[rd_ptr_q];
    assign not_empty_o = (count_q != '0);
    assign room_o      = (int'(count_q) + int'(push_i)) < DEPTH;

    always_ff @(posedge clk_i or negedge rstn_i)
    begin
        if (!rstn_i)
        begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            count_q  <= '0;
        end
        else
        begin
            if (push_i)
                wr_ptr_q <= ptr_next(wr_ptr_q);
            if (pop_i)
                rd_ptr_q <= ptr_next(rd_ptr_q);
            if (push_i && !pop_i)
                count_q <= count_q + 1'b1;
            else if (pop_i && !push_i)
                count_q <= count_q - 1'b1;
        end
    end

    always_ff @(posedge clk_i)
    begin
        if (push_i)
            mem_q[wr_ptr_q] <= data_i;
    end

endmodule

//--- verilog/udma_tx_bus_pkg.sv
// packed structs carried between the transmit blocks and the channels
// field order is fixed, the structs are also seen by the testbench
`include "udma_tx_settings.svh"

package udma_tx_bus_pkg;

    import udma_tx_cfg_pkg::*;

    // request presented by one channel
    typedef struct packed {
        l2_addr_t addr;
        tx_size_e size;
    } ch_req_t;

    // one entry of the request buffer
    typedef struct packed {
        ch_idx_t  ch;
        tx_size_e size;
        l2_addr_t addr;
    } tx_entry_t;

    //////////////////////////////////////////////////////////////////////
    // tag registered at each L2 grant, consumed in the rvalid cycle
    //////////////////////////////////////////////////////////////////////
    typedef struct packed {
        ch_idx_t  ch;
        tx_size_e size;
        lane_t    lane;
        logic     first;
        logic     last;
    } rd_tag_t;

    // response returned to a channel, valid is a single-cycle strobe
    typedef struct packed {
        logic                 valid;
        logic [`TX_L2_DW-1:0] data;
    } ch_rsp_t;

endpackage

//--- verilog/udma_tx_cfg_pkg.sv
// scalar types shared by the transmit read path
// lane_t assumes a 32-bit L2 word, four byte lanes
`include "udma_tx_settings.svh"

package udma_tx_cfg_pkg;

    //////////////////////////////////////////////////////////////////////
    // transfer size as requested by a channel
    //////////////////////////////////////////////////////////////////////
    typedef enum logic [1:0]
    {
        BYTE = 2'd0,
        HALF = 2'd1,
        WORD = 2'd2
    } tx_size_e;

    // channel number, wide enough for TX_N_CH
    typedef logic [1:0] ch_idx_t;

    // byte address inside the L2 region, prefix not included
    typedef logic [`TX_L2_AW-1:0] l2_addr_t;

    // byte offset inside one L2 word
    typedef logic [1:0] lane_t;

endpackage

//--- verilog/udma_tx_settings.svh
// build-time settings of the uDMA transmit read path
// the channel index type is 2 bits wide, so TX_N_CH must stay at 4
// TX_L2_AW + 12 prefix bits must make up the 32-bit L2 address
`ifndef UDMA_TX_SETTINGS_SVH
`define UDMA_TX_SETTINGS_SVH

// peripheral channels served by the arbiter
`define TX_N_CH 4

// L2 byte address and data bus
`define TX_L2_AW 20
`define TX_L2_DW 32

// pending read requests held between arbiter and reader
`define TX_FIFO_DEPTH 4

// fixed upper address bits of the L2 region
`define TX_L2_PREFIX 12'h1C0

`endif

//--- verilog/udma_tx_top.sv
// read side of the uDMA transmit path, four channels into one L2 port
// l2_rvalid_i must follow every l2_gnt_i by exactly one cycle
`timescale 1ns/1ps
`include "udma_tx_settings.svh"

module udma_tx_top
(
    input  logic                                     clk_i,
    input  logic                                     rstn_i,
    input  logic [`TX_N_CH-1:0]                      ch_req_valid_i,
    input  udma_tx_bus_pkg::ch_req_t [`TX_N_CH-1:0]  ch_req_i,
    output logic [`TX_N_CH-1:0]                      ch_gnt_o,
    output udma_tx_bus_pkg::ch_rsp_t [`TX_N_CH-1:0]  ch_rsp_o,
    output logic                                     l2_req_o,
    input  logic                                     l2_gnt_i,
    output logic [`TX_L2_DW-1:0]                     l2_addr_o,
    input  logic                                     l2_rvalid_i,
    input  logic [`TX_L2_DW-1:0]                     l2_rdata_i
);
    import udma_tx_bus_pkg::*;

    tx_entry_t push_entry;
    tx_entry_t head_entry;
    rd_tag_t   rd_tag;
    logic      push;
    logic      pop;
    logic      room;
    logic      not_empty;

    tx_arbiter u_arbiter (.clk_i(clk_i), .rstn_i(rstn_i), .req_valid_i(ch_req_valid_i),
        .req_i(ch_req_i), .room_i(room), .gnt_o(ch_gnt_o), .push_o(push), .entry_o(push_entry));

    tx_req_fifo #(.ENTRY_T(tx_entry_t)) u_fifo (.clk_i(clk_i), .rstn_i(rstn_i), .push_i(push),
        .data_i(push_entry), .pop_i(pop), .data_o(head_entry), .not_empty_o(not_empty),
        .room_o(room));

    tx_l2_reader u_reader (.clk_i(clk_i), .rstn_i(rstn_i), .head_i(head_entry),
        .not_empty_i(not_empty), .pop_o(pop), .l2_req_o(l2_req_o), .l2_gnt_i(l2_gnt_i),
        .l2_addr_o(l2_addr_o), .tag_o(rd_tag));

    tx_rdata_align u_align (.clk_i(clk_i), .rstn_i(rstn_i), .tag_i(rd_tag),
        .l2_rvalid_i(l2_rvalid_i), .l2_rdata_i(l2_rdata_i), .rsp_o(ch_rsp_o));

endmodule
